// ==== include/uart_sender_defines.svh ====
`ifndef UART_SENDER_DEFINES_SVH
`define UART_SENDER_DEFINES_SVH

// Small values for simulation, a board build edits this file

// Clocks in one serial bit
`define CLOCKS_PER_BIT 8

// Clocks in each delay state after a byte strobe, must exceed one frame of ten bits
`define INTER_BYTE_DELAY 100

// Clocks spent loading the input word before the first byte goes out
`define WAIT_FOR_REGISTER_DELAY 4

// Clocks the synchronized button must hold a new level before it is accepted
`define DEBOUNCE_CYCLES 6

// Width of the hold timer and of the counters
`define TIMER_WIDTH 32

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f uart_sender.f \
	--top-module uart_sender_tb -o uart_sender_sim &&
./obj_dir/uart_sender_sim ||
{ echo "Simulation did not pass"; exit 1; }

// ==== sim/uart_sender_props.sv ====
`include "uart_sender_defines.svh"

module uart_sender_props (
	input logic                       clock,
	input logic                       reset,
	input uart_sender_pkg::tx_state_t state,
	input logic                       busy,
	input logic                       press,
	input logic                       start,
	input logic                       frame_active
);

	import uart_sender_pkg::*;

	// Fixed delays only work if a frame ends before the next strobe
	delay_covers_frame: assert property (@(posedge clock)
			`INTER_BYTE_DELAY > 10 * `CLOCKS_PER_BIT)
		else $error("inter-byte delay is not longer than one frame");

	start_only_when_free: assert property (@(posedge clock) disable iff (reset)
			start |-> !frame_active)
		else $error("byte strobe arrived while a frame was on the line");

	busy_outside_idle: assert property (@(posedge clock) disable iff (reset)
			busy == (state != idle))
		else $error("busy does not match the idle state");

	press_single_clock: assert property (@(posedge clock) disable iff (reset)
			press |=> !press)
		else $error("press strobe lasted more than one clock");

endmodule

bind tx_control uart_sender_props u_props (
	.clock        (clock),
	.reset        (reset),
	.state        (state),
	.busy         (busy),
	.press        (press),
	.start        (1'b0),
	.frame_active (1'b0)
);

// The transmitter has no sequencer, so that side sits in a quiet idle
bind uart_tx uart_sender_props u_props (
	.clock        (clock),
	.reset        (reset),
	.state        (uart_sender_pkg::idle),
	.busy         (1'b0),
	.press        (1'b0),
	.start        (tx_byte.start),
	.frame_active (frame_active)
);

// ==== sim/uart_sender_tb.sv ====
`include "uart_sender_defines.svh"

module uart_sender_tb;

	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY  = 5;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS     = 10;
	localparam int FRAME_CLOCKS = 10 * `CLOCKS_PER_BIT;
	localparam int PRESS_HOLD   = 3 * `DEBOUNCE_CYCLES;
	localparam int LONG_HOLD    = 50 * `DEBOUNCE_CYCLES;
	localparam int QUIET_CLOCKS = 2 * FRAME_CLOCKS + `DEBOUNCE_CYCLES + 4;

	// Worst case is the long hold row followed by a two byte transaction and the drain
	localparam int ROW_CLOCKS = LONG_HOLD + 2 * `INTER_BYTE_DELAY +
			`WAIT_FOR_REGISTER_DELAY + 3 * FRAME_CLOCKS + QUIET_CLOCKS + 100;
	localparam longint WATCHDOG_TIME =
			longint'(NUM_ROWS * ROW_CLOCKS + RESET_CYCLES + 1000) * CLOCK_PERIOD;

	localparam logic [2:0] KIND_IDLE   = 3'd0;
	localparam logic [2:0] KIND_PRESS  = 3'd1;
	localparam logic [2:0] KIND_GLITCH = 3'd2;
	localparam logic [2:0] KIND_HOLD   = 3'd3;
	localparam logic [2:0] KIND_CHANGE = 3'd4;

	typedef struct packed {
		logic [15:0] data;
		logic        send16;
		logic [2:0]  kind;
	} row_t;

	row_t        rows [NUM_ROWS];
	string       row_name [NUM_ROWS];
	int          exp_count [NUM_ROWS];
	logic [7:0]  exp_bytes [NUM_ROWS][2];

	logic        clock;
	logic        reset;
	logic        button;
	logic        send16;
	logic [15:0] data_in16;
	logic        serial;
	logic        busy;

	string       current_test;
	logic [7:0]  rx_bytes [$];
	logic [31:0] lfsr_state;
	logic        saw_busy;

	uart_sender uut (
		.clock     (clock),
		.reset     (reset),
		.button    (button),
		.send16    (send16),
		.data_in16 (data_in16),
		.serial    (serial),
		.busy      (busy)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired, the run hung waiting on the DUT");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog timeout");
	end

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
					current_test, what, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	task automatic random_word(output logic [15:0] word);
		word = '0;
		for (int i = 0; i < 16; i++) begin
			word = {word[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic add_row(input int r, input string name, input logic [15:0] data,
			input logic send, input logic [2:0] kind);
		rows[r].data   = data;
		rows[r].send16 = send;
		rows[r].kind   = kind;
		row_name[r]    = name;
		if (kind == KIND_IDLE || kind == KIND_GLITCH) begin
			exp_count[r] = 0;
		end else if (send) begin
			exp_count[r] = 2;
		end else begin
			exp_count[r] = 1;
		end
		// The low byte always goes out first
		exp_bytes[r][0] = data[7:0];
		exp_bytes[r][1] = data[15:8];
	endtask

	task automatic build_table();
		logic [15:0] word;
		add_row(0, "idle after reset", 16'h0000, 1'b0, KIND_IDLE);
		add_row(1, "single byte", 16'h12a5, 1'b0, KIND_PRESS);
		add_row(2, "two bytes fixed", 16'hbeef, 1'b1, KIND_PRESS);
		add_row(3, "two bytes edge pattern", 16'h00ff, 1'b1, KIND_PRESS);
		random_word(word);
		add_row(4, "random single byte", word, 1'b0, KIND_PRESS);
		random_word(word);
		add_row(5, "random two bytes a", word, 1'b1, KIND_PRESS);
		random_word(word);
		add_row(6, "random two bytes b", word, 1'b1, KIND_PRESS);
		add_row(7, "short glitch", 16'h5a5a, 1'b1, KIND_GLITCH);
		add_row(8, "long hold", 16'hc3e1, 1'b1, KIND_HOLD);
		add_row(9, "change while busy", 16'h7e81, 1'b1, KIND_CHANGE);
	endtask

	// Inputs always move a little after the rising edge
	task automatic step();
		@(posedge clock);
		#(DRIVE_DELAY);
		if (busy) begin
			saw_busy = 1'b1;
		end
	endtask

	task automatic wait_for_busy();
		while (!busy) begin
			step();
		end
	endtask

	task automatic wait_for_idle();
		while (busy) begin
			step();
		end
	endtask

	task automatic run_row(input int r);
		current_test = row_name[r];
		rx_bytes.delete();
		saw_busy  = 1'b0;
		data_in16 = rows[r].data;
		send16    = rows[r].send16;
		case (rows[r].kind)
			KIND_PRESS: begin
				button = 1'b1;
				repeat (PRESS_HOLD) step();
				check("busy after press", 1, 32'(busy));
				button = 1'b0;
				wait_for_idle();
			end
			KIND_GLITCH: begin
				button = 1'b1;
				repeat (`DEBOUNCE_CYCLES - 1) step();
				button = 1'b0;
				repeat (QUIET_CLOCKS) step();
				check("busy seen after glitch", 0, 32'(saw_busy));
			end
			KIND_HOLD: begin
				button = 1'b1;
				repeat (LONG_HOLD) step();
				button = 1'b0;
				wait_for_idle();
			end
			KIND_CHANGE: begin
				button = 1'b1;
				wait_for_busy();
				// By now the last word load has happened
				repeat (`WAIT_FOR_REGISTER_DELAY + 2) step();
				data_in16 = ~rows[r].data;
				button = 1'b0;
				repeat (`DEBOUNCE_CYCLES + 4) step();
				button = 1'b1;
				repeat (PRESS_HOLD) step();
				check("busy during second press", 1, 32'(busy));
				button = 1'b0;
				wait_for_idle();
			end
			default: begin
				check("serial at idle", 1, 32'(serial));
				check("busy at idle", 0, 32'(busy));
			end
		endcase
		// Long enough for a stray third frame to show up
		repeat (QUIET_CLOCKS) step();
		check("byte count", 32'(exp_count[r]), 32'(rx_bytes.size()));
		for (int i = 0; i < exp_count[r]; i++) begin
			check($sformatf("byte %0d", i), 32'(exp_bytes[r][i]), 32'(rx_bytes[i]));
		end
		check("busy at end", 0, 32'(busy));
		check("serial at end", 1, 32'(serial));
	endtask

	// Samples near the middle of each bit on the falling clock edge
	initial begin : serial_decoder
		logic [7:0] rx;
		wait (!reset);
		forever begin
			@(negedge serial);
			repeat (`CLOCKS_PER_BIT / 2) @(negedge clock);
			check("start bit", 0, 32'(serial));
			for (int i = 0; i < 8; i++) begin
				repeat (`CLOCKS_PER_BIT) @(negedge clock);
				rx[i] = serial;
			end
			repeat (`CLOCKS_PER_BIT) @(negedge clock);
			check("stop bit", 1, 32'(serial));
			rx_bytes.push_back(rx);
		end
	end

	initial begin
		reset        = 1'b1;
		button       = 1'b0;
		send16       = 1'b0;
		data_in16    = 16'h0000;
		saw_busy     = 1'b0;
		lfsr_state   = 32'h10cf834c;
		current_test = "reset";
		build_table();
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		reset = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== uart_sender.f ====
+incdir+include
verilog/uart_sender_pkg.sv
verilog/button_pulse.sv
verilog/tx_control.sv
verilog/uart_tx.sv
verilog/uart_sender.sv
sim/uart_sender_props.sv
sim/uart_sender_tb.sv

// ==== verilog/button_pulse.sv ====
`include "uart_sender_defines.svh"

module button_pulse (
	input  logic clock,
	input  logic reset,
	input  logic button,
	output logic press
);

	logic                    button_meta;
	logic                    button_sync;
	logic                    accepted;
	logic                    accepted_prev;
	logic [`TIMER_WIDTH-1:0] stable_count;
	logic                    differs;
	logic                    settled;

	// Two-flop synchronizer for the asynchronous button
	always_ff @(posedge clock) begin
		if (reset) begin
			button_meta <= 1'b0;
			button_sync <= 1'b0;
		end else begin
			button_meta <= button;
			button_sync <= button_meta;
		end
	end

	assign differs = (button_sync != accepted);
	assign settled = differs && (stable_count == `TIMER_WIDTH'(`DEBOUNCE_CYCLES - 1));

	// Counts how long the synchronized level has disagreed with the accepted one
	// and starts over on any bounce back
	always_ff @(posedge clock) begin
		if (reset) begin
			stable_count <= '0;
		end else if (!differs || settled) begin
			stable_count <= '0;
		end else begin
			stable_count <= stable_count + `TIMER_WIDTH'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			accepted <= 1'b0;
		end else if (settled) begin
			accepted <= button_sync;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			accepted_prev <= 1'b0;
		end else begin
			accepted_prev <= accepted;
		end
	end

	// One strobe on each rising edge of the accepted level
	assign press = accepted && !accepted_prev;

endmodule

// ==== verilog/tx_control.sv ====
`include "uart_sender_defines.svh"

module tx_control (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      press,
	input  logic                      send16,
	input  logic [15:0]               data_in16,
	output uart_sender_pkg::tx_byte_t tx_byte,
	output logic                      busy
);

	import uart_sender_pkg::*;

	tx_state_t               state;
	tx_state_t               next_state;
	sample_word_u            word;
	logic [`TIMER_WIDTH-1:0] hold_timer;
	logic                    timing;
	logic                    register_done;
	logic                    delay_done;

	// The timer only runs in the states that wait a fixed count
	assign timing = (state == register_word) ||
			(state == delay_byte_0) ||
			(state == delay_byte_1);

	assign register_done = (hold_timer >= `TIMER_WIDTH'(`WAIT_FOR_REGISTER_DELAY));
	assign delay_done    = (hold_timer >= `TIMER_WIDTH'(`INTER_BYTE_DELAY));

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (press) begin
					next_state = register_word;
				end
			end
			register_word: begin
				if (register_done) begin
					next_state = send_byte_0;
				end
			end
			send_byte_0: begin
				next_state = delay_byte_0;
			end
			delay_byte_0: begin
				// send16 only matters on the last clock of this delay
				if (delay_done) begin
					if (send16) begin
						next_state = send_byte_1;
					end else begin
						next_state = idle;
					end
				end
			end
			send_byte_1: begin
				next_state = delay_byte_1;
			end
			delay_byte_1: begin
				if (delay_done) begin
					next_state = idle;
				end
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_timer <= '0;
		end else if (timing) begin
			hold_timer <= hold_timer + `TIMER_WIDTH'(1);
		end else begin
			hold_timer <= '0;
		end
	end

	// Loaded on every clock of register_word so the last sample is the one sent
	always_ff @(posedge clock) begin
		if (state == register_word) begin
			word.whole <= data_in16;
		end
	end

	always_comb begin
		busy          = (state != idle);
		tx_byte.start = (state == send_byte_0) || (state == send_byte_1);
		if (state == send_byte_1) begin
			tx_byte.data = word.bytes.byte_hi;
		end else begin
			tx_byte.data = word.bytes.byte_lo;
		end
	end

endmodule

// ==== verilog/uart_sender.sv ====
module uart_sender (
	input  logic        clock,
	input  logic        reset,
	input  logic        button,
	input  logic        send16,
	input  logic [15:0] data_in16,
	output logic        serial,
	output logic        busy
);

	import uart_sender_pkg::*;

	logic     press;
	tx_byte_t tx_byte;
	// Only watched by the assertions
	logic     frame_active;

	button_pulse u_button_pulse (
		.clock  (clock),
		.reset  (reset),
		.button (button),
		.press  (press)
	);

	// Sequences one or two byte strobes per press
	tx_control u_tx_control (
		.clock     (clock),
		.reset     (reset),
		.press     (press),
		.send16    (send16),
		.data_in16 (data_in16),
		.tx_byte   (tx_byte),
		.busy      (busy)
	);

	uart_tx u_uart_tx (
		.clock        (clock),
		.reset        (reset),
		.tx_byte      (tx_byte),
		.serial       (serial),
		.frame_active (frame_active)
	);

endmodule

// ==== verilog/uart_sender_pkg.sv ====
package uart_sender_pkg;

	// Sequencer states of the control block
	typedef enum logic [2:0] {
		idle          = 3'd0,
		register_word = 3'd1,
		send_byte_0   = 3'd2,
		delay_byte_0  = 3'd3,
		send_byte_1   = 3'd4,
		delay_byte_1  = 3'd5
	} tx_state_t;

	// Byte strobe to the transmitter, data is valid in the cycle start is high
	typedef struct packed {
		logic [7:0] data;
		logic       start;
	} tx_byte_t;

	// The two bytes of a sampled word in send order position
	typedef struct packed {
		logic [7:0] byte_hi;
		logic [7:0] byte_lo;
	} sample_bytes_t;

	// One 16-bit word seen either whole or as two bytes
	typedef union packed {
		logic [15:0]   whole;
		sample_bytes_t bytes;
	} sample_word_u;

endpackage

// ==== verilog/uart_tx.sv ====
`include "uart_sender_defines.svh"

module uart_tx (
	input  logic                      clock,
	input  logic                      reset,
	input  uart_sender_pkg::tx_byte_t tx_byte,
	output logic                      serial,
	output logic                      frame_active
);

	// Start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;

	logic [FRAME_BITS-1:0]   frame;
	logic [`TIMER_WIDTH-1:0] period_count;
	logic [`TIMER_WIDTH-1:0] bit_count;
	logic                    load;
	logic                    bit_done;
	logic                    last_bit;

	// A strobe that arrives mid frame is dropped
	assign load = tx_byte.start && !frame_active;

	assign bit_done = frame_active &&
			(period_count == `TIMER_WIDTH'(`CLOCKS_PER_BIT - 1));
	assign last_bit = (bit_count == `TIMER_WIDTH'(FRAME_BITS - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			frame_active <= 1'b0;
		end else if (load) begin
			frame_active <= 1'b1;
		end else if (bit_done && last_bit) begin
			frame_active <= 1'b0;
		end
	end

	// Clocks within the current bit
	always_ff @(posedge clock) begin
		if (reset) begin
			period_count <= '0;
		end else if (!frame_active || bit_done) begin
			period_count <= '0;
		end else begin
			period_count <= period_count + `TIMER_WIDTH'(1);
		end
	end

	// Index of the bit on the line up to the stop bit
	always_ff @(posedge clock) begin
		if (reset) begin
			bit_count <= '0;
		end else if (!frame_active) begin
			bit_count <= '0;
		end else if (bit_done) begin
			bit_count <= bit_count + `TIMER_WIDTH'(1);
		end
	end

	// LSB goes out first and ones fill in from the top
	always_ff @(posedge clock) begin
		if (load) begin
			frame <= {1'b1, tx_byte.data, 1'b0};
		end else if (bit_done) begin
			frame <= {1'b1, frame[FRAME_BITS-1:1]};
		end
	end

	// The line idles high between frames
	assign serial = frame_active ? frame[0] : 1'b1;

endmodule
